// File: design/bec_ctrl.sv
`default_nettype none

module bec_ctrl
(
	input  logic               rst,
	input  logic               clk,
	input  bec_pkg::bec_cond_t cond,
	input  logic               key,
	output bec_pkg::bec_ctrl_t ctrl
);

	import bec_pkg::*;

	bec_state_t                 state;
	bec_state_t                 state_nx;
	bec_state_t                 disp_nx;
	bec_ctrl_t                  disp_ctrl;
	logic [corrupt_count_w-1:0] corrupt_count;
	logic                       exit_y34;
	logic                       alt_to_s7;

	// ##################################################
	// state and visit counter
	// ##################################################

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			state         <= s1;
			corrupt_count <= '0;
		end
		else
		begin
			state <= state_nx;
			if (state_nx == s8 && corrupt_count != corrupt_limit)
				corrupt_count <= corrupt_count + 1'b1; // saturates.
		end
	end

	// ##################################################
	// shared decode terms
	// ##################################################

	assign exit_y34 = cond.x14 && (cond.x10 || cond.x11);

	// s6 with x6 set and x3 clear, x15 set.
	always_comb
	begin
		case ({cond.x8, cond.x9})
			2'b11:   alt_to_s7 = !cond.x16;
			2'b10:   alt_to_s7 = cond.x17;
			2'b01:   alt_to_s7 = cond.x18;
			default: alt_to_s7 = !cond.x18;
		endcase
	end

	// dispatch table of s8, s8_d and the low x6, x3 leg of s6.
	always_comb
	begin
		disp_ctrl = '0;
		if (cond.x12)
		begin
			if (cond.x4)
			begin
				disp_ctrl.y5 = 1'b1;
				disp_nx      = s9;
			end
			else if (cond.x5)
			begin
				{disp_ctrl.y6, disp_ctrl.y15} = 2'b11;
				disp_nx                       = s10;
			end
			else
			begin
				disp_ctrl.y14 = 1'b1;
				disp_nx       = s7;
			end
		end
		else if (!cond.x4)
		begin
			disp_ctrl.y5 = 1'b1;
			disp_nx      = s12;
		end
		else if (cond.x5)
		begin
			disp_ctrl.y11 = 1'b1;
			disp_nx       = s7;
		end
		else
		begin
			disp_ctrl.y5 = 1'b1;
			disp_nx      = s11;
		end
	end

	// ##################################################
	// next state and strobes
	// ##################################################

	always_comb
	begin
		ctrl     = '0;
		state_nx = state;
		case (state)
			s1:
			begin
				if (cond.x1 && cond.x2)
				begin
					{ctrl.y35, ctrl.y36} = 2'b11;
					state_nx             = s2;
				end
				else if (cond.x1)
				begin
					ctrl.y1  = 1'b1;
					state_nx = s3;
				end
			end
			s2:
			begin
				{ctrl.y37, ctrl.y38} = 2'b11;
				state_nx             = s4;
			end
			s3:
			begin
				{ctrl.y2, ctrl.y3} = 2'b11;
				state_nx           = s5;
			end
			s4:
			begin
				{ctrl.y3, ctrl.y28, ctrl.y34} = 3'b111;
				state_nx                      = s1;
			end
			s5:
			begin
				ctrl.y39 = 1'b1;
				state_nx = s6;
			end
			s6:
			begin
				if (cond.x6 && cond.x3)
				begin
					state_nx = s7;
					if (cond.x7)
					begin
						ctrl.y28 = cond.x9;
						ctrl.y29 = !cond.x9;
					end
					else if (!cond.x8)
					begin
						{ctrl.y32, ctrl.y33} = {2{cond.x9}};
						{ctrl.y30, ctrl.y31} = {2{!cond.x9}};
					end
					else if (cond.x9 ? cond.x11 : cond.x10)
						ctrl.y3 = 1'b1;
					else
					begin
						ctrl.y34 = exit_y34;
						state_nx = s1;
					end
				end
				else if (cond.x6 && cond.x15)
				begin
					ctrl.y3  = alt_to_s7;
					ctrl.y34 = !alt_to_s7 && exit_y34;
					state_nx = alt_to_s7 ? s7 : s1;
				end
				else if (cond.x6)
				begin
					state_nx = s7;
					case ({cond.x7, cond.x8, cond.x9})
						3'b111:  ctrl.y16 = 1'b1;
						3'b110:  ctrl.y17 = 1'b1;
						3'b101:  ctrl.y19 = 1'b1;
						3'b100:  ctrl.y18 = 1'b1;
						3'b011:  {ctrl.y25, ctrl.y26, ctrl.y27} = 3'b111;
						3'b010:  {ctrl.y22, ctrl.y23, ctrl.y24} = 3'b111;
						3'b001:  ctrl.y20 = 1'b1;
						default: ctrl.y21 = 1'b1;
					endcase
				end
				else if (cond.x3)
				begin
					// key 1 takes the counted path.
					ctrl.y4  = 1'b1;
					state_nx = key ? s8 : s8_d;
				end
				else
				begin
					ctrl     = disp_ctrl;
					state_nx = disp_nx;
				end
			end
			s7:
			begin
				ctrl.y34 = exit_y34;
				state_nx = s1;
			end
			s8:
			begin
				state_nx = disp_nx;
				if (corrupt_count < corrupt_limit)
					ctrl = disp_ctrl; // blank from the fifth visit.
			end
			s8_d:
			begin
				ctrl     = disp_ctrl;
				state_nx = disp_nx;
			end
			s9:
			begin
				ctrl.y12 = 1'b1;
				state_nx = s13;
			end
			s10:
			begin
				ctrl.y14 = 1'b1;
				state_nx = s7;
			end
			s11:
			begin
				ctrl.y7  = 1'b1;
				state_nx = s7;
			end
			s12:
			begin
				{ctrl.y8, ctrl.y9} = {2{cond.x5}};
				ctrl.y10           = !cond.x5;
				state_nx           = s7;
			end
			s13:
			begin
				ctrl.y13 = 1'b1;
				state_nx = s14;
			end
			s14:
			begin
				ctrl.y3  = cond.x13;
				ctrl.y34 = !cond.x13 && exit_y34;
				state_nx = cond.x13 ? s7 : s1;
			end
			default: state_nx = s1;
		endcase
	end

endmodule

`default_nettype wire

// File: design/bec_key_store.sv
`default_nettype none

module bec_key_store
(
	input  logic                  rst,
	input  logic                  clk,
	input  bec_pkg::bec_key_req_t key_req,
	output logic                  key,
	output logic                  loaded
);

	import bec_pkg::*;

	logic take; // first request since reset.

	assign take = key_req.key_valid && !loaded;

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			key    <= key_reset_value;
			loaded <= 1'b0;
		end
		else if (take)
		begin
			// later requests are ignored until reset.
			key    <= key_req.key_bit;
			loaded <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/bec_pkg.sv
`default_nettype none

package bec_pkg;

	// ##################################################
	// controller states
	// ##################################################

	typedef enum logic [3:0]
	{
		s1   = 4'd1,
		s2   = 4'd2,
		s3   = 4'd3,
		s4   = 4'd4,
		s5   = 4'd5,
		s6   = 4'd6,
		s7   = 4'd7,
		s8   = 4'd8,  // entered with key 1.
		s9   = 4'd9,
		s10  = 4'd10,
		s11  = 4'd11,
		s12  = 4'd12,
		s13  = 4'd13,
		s14  = 4'd14,
		s8_d = 4'd15  // entered with key 0.
	} bec_state_t;

	// ##################################################
	// condition and strobe words
	// ##################################################

	// x1 sits in bit 0.
	typedef struct packed
	{
		logic x18, x17, x16, x15, x14, x13;
		logic x12, x11, x10, x9, x8, x7;
		logic x6, x5, x4, x3, x2, x1;
	} bec_cond_t;

	// y1 sits in bit 0.
	typedef struct packed
	{
		logic y39, y38, y37, y36, y35, y34, y33, y32;
		logic y31, y30, y29, y28, y27, y26, y25, y24;
		logic y23, y22, y21, y20, y19, y18, y17, y16;
		logic y15, y14, y13, y12, y11, y10, y9, y8;
		logic y7, y6, y5, y4, y3, y2, y1;
	} bec_ctrl_t;

	// key load request.
	typedef struct packed
	{
		logic key_valid;
		logic key_bit;
	} bec_key_req_t;

	// ##################################################
	// lock constants
	// ##################################################

	localparam int unsigned corrupt_count_w = 3;

	// first s8 visit with blanked strobes.
	localparam logic [corrupt_count_w-1:0] corrupt_limit = 3'd5;

	// unloaded key runs the part locked.
	localparam logic key_reset_value = 1'b1;

endpackage

`default_nettype wire

// File: design/bec_sync.sv
`default_nettype none

// two flops per bit for a crossing from another clock domain.
module bec_sync
#(
	parameter type payload_t = logic
)
(
	input  logic     rst,
	input  logic     clk,
	input  payload_t d,
	output payload_t q
);

	payload_t meta; // first stage may go metastable.

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			meta <= '0;
			q    <= '0;
		end
		else
		begin
			meta <= d;
			q    <= meta;
		end
	end

endmodule

`default_nettype wire

// File: design/bec_top.sv
`default_nettype none

module bec_top
(
	input  logic                  rst,
	input  logic                  clk,
	input  bec_pkg::bec_cond_t    cond,
	input  bec_pkg::bec_key_req_t key_req,
	output bec_pkg::bec_ctrl_t    ctrl,
	output logic                  key_loaded
);

	import bec_pkg::*;

	bec_cond_t    cond_s;
	bec_key_req_t key_req_s;
	logic         key;

	bec_sync #(.payload_t(bec_cond_t)) i_cond_sync
	(
		.rst (rst),
		.clk (clk),
		.d   (cond),
		.q   (cond_s)
	);

	bec_sync #(.payload_t(bec_key_req_t)) i_key_sync
	(
		.rst (rst),
		.clk (clk),
		.d   (key_req),
		.q   (key_req_s)
	);

	bec_key_store i_key_store
	(
		.rst     (rst),
		.clk     (clk),
		.key_req (key_req_s),
		.key     (key),
		.loaded  (key_loaded)
	);

	bec_ctrl i_ctrl
	(
		.rst  (rst),
		.clk  (clk),
		.cond (cond_s),
		.key  (key),
		.ctrl (ctrl)
	);

endmodule

`default_nettype wire

// File: flist.f
design/bec_pkg.sv
design/bec_sync.sv
design/bec_key_store.sv
design/bec_ctrl.sv
design/bec_top.sv
test/bec_assert.sv
test/bec_tb.sv

// File: run.sh
#!/bin/sh
# build and run the bec testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module bec_tb -o bec_sim \
	&& ./obj_dir/bec_sim | tee /dev/stderr | grep -q "Result: PASSED" \
	&& echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }

// File: test/bec_assert.sv
`default_nettype none

module bec_assert
(
	input logic                                rst,
	input logic                                clk,
	input bec_pkg::bec_state_t                 state,
	input bec_pkg::bec_ctrl_t                  ctrl,
	input logic [bec_pkg::corrupt_count_w-1:0] corrupt_count
);

	timeunit 1ns;
	timeprecision 1ps;

	import bec_pkg::*;

	state_legal: assert property (@(posedge rst) disable iff (!clk)
		state inside {s1, s2, s3, s4, s5, s6, s7, s8, s9, s10, s11, s12, s13, s14, s8_d})
		else $error("controller state has an illegal encoding");

	// y4 marks the key branch out of s6.
	y4_in_s6: assert property (@(posedge rst) disable iff (!clk)
		ctrl.y4 |-> state == s6)
		else $error("y4 raised outside s6");

	count_bound: assert property (@(posedge rst) disable iff (!clk)
		corrupt_count <= corrupt_limit)
		else $error("corruption counter passed its limit");

endmodule

bind bec_ctrl bec_assert i_assert
(
	.rst           (rst),
	.clk           (clk),
	.state         (state),
	.ctrl          (ctrl),
	.corrupt_count (corrupt_count)
);

`default_nettype wire

// File: test/bec_tb.sv
`default_nettype none

module bec_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import bec_pkg::*;

	logic         rst; // clock.
	logic         clk; // reset, active low.
	bec_cond_t    cond;
	bec_key_req_t key_req;
	bec_ctrl_t    ctrl;
	logic         key_loaded;

	logic [31:0]  lfsr;
	int           errors;
	int           tests_passed;
	int           tests_failed;

	bec_cond_t    m_d1;
	bec_cond_t    m_d2;
	bec_key_req_t m_k1;
	bec_key_req_t m_k2;
	bec_state_t   m_state;
	logic [2:0]   m_count;
	logic         m_key;
	logic         m_loaded;
	int           m_visits_s8;
	int           m_visits_s8d;
	logic [39:1]  check_y;
	bec_state_t   check_nx;

	bec_top i_bec_top
	(
		.rst        (rst),
		.clk        (clk),
		.cond       (cond),
		.key_req    (key_req),
		.ctrl       (ctrl),
		.key_loaded (key_loaded)
	);

	always #50 rst = ~rst;

	// ##################################################
	// reference model of the control table
	// ##################################################

	task automatic model_eval
	(
		input  bec_state_t  st,
		input  bec_cond_t   c,
		input  logic        k,
		input  logic [2:0]  cnt,
		output logic [39:1] y,
		output bec_state_t  nx
	);
		logic        e;
		logic        a;
		logic [39:1] dy;
		bec_state_t  dn;
		e = c.x14 & (c.x10 | c.x11); // common exit strobe.
		case ({c.x8, c.x9})
			2'b11:   a = !c.x16;
			2'b10:   a = c.x17;
			2'b01:   a = c.x18;
			default: a = !c.x18;
		endcase
		dy = '0;
		if (c.x12 && c.x4)
		begin
			dy[5] = 1'b1;
			dn    = s9;
		end
		else if (c.x12 && c.x5)
		begin
			dy[6]  = 1'b1;
			dy[15] = 1'b1;
			dn     = s10;
		end
		else if (c.x12)
		begin
			dy[14] = 1'b1;
			dn     = s7;
		end
		else if (!c.x4)
		begin
			dy[5] = 1'b1;
			dn    = s12;
		end
		else if (c.x5)
		begin
			dy[11] = 1'b1;
			dn     = s7;
		end
		else
		begin
			dy[5] = 1'b1;
			dn    = s11;
		end
		y  = '0;
		nx = st;
		case (st)
			s1:
			begin
				if (c.x1 && c.x2)
				begin
					y[36:35] = 2'b11;
					nx       = s2;
				end
				else if (c.x1)
				begin
					y[1] = 1'b1;
					nx   = s3;
				end
			end
			s2:
			begin
				y[38:37] = 2'b11;
				nx       = s4;
			end
			s3:
			begin
				y[3:2] = 2'b11;
				nx     = s5;
			end
			s4:
			begin
				y[3]  = 1'b1;
				y[28] = 1'b1;
				y[34] = 1'b1;
				nx    = s1;
			end
			s5:
			begin
				y[39] = 1'b1;
				nx    = s6;
			end
			s6:
			begin
				if (c.x6 && c.x3)
				begin
					nx = s7;
					if (c.x7)
					begin
						y[28] = c.x9;
						y[29] = !c.x9;
					end
					else if (!c.x8)
					begin
						y[33:32] = {2{c.x9}};
						y[31:30] = {2{!c.x9}};
					end
					else if (c.x9 ? c.x11 : c.x10)
						y[3] = 1'b1;
					else
					begin
						y[34] = e;
						nx    = s1;
					end
				end
				else if (c.x6 && c.x15)
				begin
					y[3]  = a;
					y[34] = !a && e;
					nx    = a ? s7 : s1;
				end
				else if (c.x6)
				begin
					nx = s7;
					case ({c.x7, c.x8, c.x9})
						3'b111:  y[16] = 1'b1;
						3'b110:  y[17] = 1'b1;
						3'b101:  y[19] = 1'b1;
						3'b100:  y[18] = 1'b1;
						3'b011:  y[27:25] = 3'b111;
						3'b010:  y[24:22] = 3'b111;
						3'b001:  y[20] = 1'b1;
						default: y[21] = 1'b1;
					endcase
				end
				else if (c.x3)
				begin
					y[4] = 1'b1;
					nx   = k ? s8 : s8_d;
				end
				else
				begin
					y  = dy;
					nx = dn;
				end
			end
			s7:
			begin
				y[34] = e;
				nx    = s1;
			end
			s8:
			begin
				nx = dn;
				if (cnt < corrupt_limit)
					y = dy; // count already holds this visit.
			end
			s8_d:
			begin
				y  = dy;
				nx = dn;
			end
			s9:
			begin
				y[12] = 1'b1;
				nx    = s13;
			end
			s10:
			begin
				y[14] = 1'b1;
				nx    = s7;
			end
			s11:
			begin
				y[7] = 1'b1;
				nx   = s7;
			end
			s12:
			begin
				y[9:8] = {2{c.x5}};
				y[10]  = !c.x5;
				nx     = s7;
			end
			s13:
			begin
				y[13] = 1'b1;
				nx    = s14;
			end
			s14:
			begin
				y[3]  = c.x13;
				y[34] = !c.x13 && e;
				nx    = c.x13 ? s7 : s1;
			end
			default: nx = s1;
		endcase
	endtask

	always @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			m_d1     <= '0;
			m_d2     <= '0;
			m_k1     <= '0;
			m_k2     <= '0;
			m_state  <= s1;
			m_count  <= '0;
			m_key    <= 1'b1; // unloaded part runs locked.
			m_loaded <= 1'b0;
		end
		else
		begin
			m_state <= check_nx;
			if (check_nx == s8 && m_count < 3'd5)
				m_count <= m_count + 3'd1;
			if (check_nx == s8)
				m_visits_s8 <= m_visits_s8 + 1;
			if (check_nx == s8_d)
				m_visits_s8d <= m_visits_s8d + 1;
			if (m_k2.key_valid && !m_loaded)
			begin
				m_key    <= m_k2.key_bit;
				m_loaded <= 1'b1;
			end
			m_d1 <= cond;
			m_d2 <= m_d1;
			m_k1 <= key_req;
			m_k2 <= m_k1;
		end
	end

	// model step and per-cycle compare on the falling edge.
	always @(negedge rst)
	begin
		model_eval(m_state, m_d2, m_key, m_count, check_y, check_nx);
		if (clk)
		begin
			if (ctrl !== check_y)
			begin
				errors++;
				$display("ERROR %0t: ctrl in state %s, expected %h got %h",
					$time, m_state.name(), check_y, ctrl);
			end
			if (i_bec_top.i_ctrl.state !== m_state)
			begin
				errors++;
				$display("ERROR %0t: state expected %s got %0d",
					$time, m_state.name(), i_bec_top.i_ctrl.state);
			end
			if (m_state == s8 && m_count >= 3'd5 && ctrl !== '0)
			begin
				errors++;
				$display("ERROR %0t: s8 strobes not blanked on visit %0d", $time, m_count);
			end
		end
	end

	// ##################################################
	// stimulus
	// ##################################################

	function automatic logic next_bit();
		logic b;
		b    = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return b;
	endfunction

	function automatic bec_cond_t random_cond(input logic bias);
		bec_cond_t c;
		for (int i = 0; i < 18; i++)
			c[i] = next_bit();
		if (bias)
		begin
			// steer s1 to s3 and s6 into the key branch.
			c.x1 = next_bit() | next_bit();
			c.x2 = next_bit() & next_bit();
			c.x6 = next_bit() & next_bit();
			c.x3 = next_bit() | next_bit();
		end
		return c;
	endfunction

	task automatic apply_reset();
		@(negedge rst);
		clk     = 1'b0;
		cond    = '0;
		key_req = '0;
		repeat (10) @(negedge rst);
		clk = 1'b1;
	endtask

	task automatic run_cycles(input int n, input logic bias);
		repeat (n)
		begin
			@(negedge rst);
			cond = random_cond(bias);
		end
	endtask

	task automatic request_key(input logic kb);
		@(negedge rst);
		key_req.key_valid = 1'b1;
		key_req.key_bit   = kb;
		@(negedge rst);
		key_req = '0;
	endtask

	task automatic load_key(input logic kb);
		int waited;
		request_key(kb);
		waited = 0;
		while (!key_loaded && waited < 10)
		begin
			@(negedge rst);
			waited++;
		end
		if (!key_loaded)
		begin
			errors++;
			$display("timeout: key_loaded did not rise within 10 cycles");
		end
	endtask

	task automatic report_test(input string name, input int start);
		@(posedge rst); // let the last compare finish.
		if (errors == start)
		begin
			tests_passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - start);
		end
	endtask

	// ##################################################
	// tests
	// ##################################################

	task automatic test_reset_values();
		int start;
		start = errors;
		repeat (3)
		begin
			@(negedge rst);
			if (ctrl !== '0 || key_loaded !== 1'b0)
			begin
				errors++;
				$display("ERROR %0t: after reset ctrl %h key_loaded %b", $time, ctrl, key_loaded);
			end
		end
		report_test("reset_values", start);
	endtask

	task automatic test_correct_key();
		int start;
		int s8d0;
		start = errors;
		s8d0  = m_visits_s8d;
		load_key(1'b0);
		run_cycles(2000, 1'b0);
		if (m_visits_s8d == s8d0)
		begin
			errors++;
			$display("correct_key: s8_d was never reached");
		end
		report_test("correct_key", start);
	endtask

	task automatic test_write_once();
		int start;
		int s80;
		int s8d0;
		start = errors;
		s80   = m_visits_s8;
		s8d0  = m_visits_s8d;
		request_key(1'b1);
		repeat (6)
		begin
			@(negedge rst);
			if (!key_loaded)
			begin
				errors++;
				$display("ERROR %0t: key_loaded dropped after a second request", $time);
			end
		end
		run_cycles(1000, 1'b1);
		if (m_visits_s8 != s80 || m_visits_s8d == s8d0)
		begin
			errors++;
			$display("write_once: the s6 branch did not follow the first key");
		end
		report_test("write_once", start);
	endtask

	task automatic test_wrong_key();
		int start;
		int s80;
		start = errors;
		apply_reset();
		s80 = m_visits_s8;
		load_key(1'b1);
		run_cycles(1500, 1'b1);
		if (m_visits_s8 - s80 < 6)
		begin
			errors++;
			$display("wrong_key: fewer than six visits to s8");
		end
		report_test("wrong_key", start);
	endtask

	task automatic test_unloaded();
		int start;
		int s80;
		int s8d0;
		start = errors;
		apply_reset();
		s80  = m_visits_s8;
		s8d0 = m_visits_s8d;
		run_cycles(800, 1'b1);
		if (key_loaded)
		begin
			errors++;
			$display("ERROR %0t: key_loaded set with no load requested", $time);
		end
		if (m_visits_s8 - s80 < 6 || m_visits_s8d != s8d0)
		begin
			errors++;
			$display("unloaded: the part did not run as with key 1");
		end
		report_test("unloaded", start);
	endtask

	initial
	begin
		rst          = 1'b0;
		clk          = 1'b0;
		cond         = '0;
		key_req      = '0;
		lfsr         = 32'h27e9_da8a;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		m_visits_s8  = 0;
		m_visits_s8d = 0;
		apply_reset();
		test_reset_values();
		test_correct_key();
		test_write_once();
		test_wrong_key();
		test_unloaded();
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
